/* logic/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    // Size of Z, holds the full product
    localparam int dword_width = 64;

    // Encodings follow the ISA instruction opcodes
    typedef enum logic [4:0] {
        op_add = 5'b00011,
        op_sub = 5'b00100,
        op_and = 5'b00101,
        op_or  = 5'b00110,
        op_shr = 5'b01001,
        op_shl = 5'b01011,
        op_mul = 5'b10000,
        op_neg = 5'b10001,
        op_not = 5'b10010
    } alu_op_t;

endpackage

`default_nettype wire

/* logic/alu_stage.sv */
`default_nettype none

module alu_stage
    import cpu_defs_pkg::*;
    import alu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    y_in,
    input  wire logic    z_in,
    input  wire logic    hi_in,
    input  wire logic    lo_in,
    input  wire alu_op_t opcode,
    input  wire word_t   bus_word,
    output word_t        hi,
    output word_t        lo,
    output word_t        zhigh,
    output word_t        zlow
);

    word_t                  y_q;
    logic [dword_width-1:0] z_q;
    logic [dword_width-1:0] result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            y_q <= '0;
        end else if (y_in) begin
            y_q <= bus_word;
        end
    end

    // Y is the A operand, bus is B
    always_comb begin
        result = '0;
        case (opcode)
            op_add: result[word_width-1:0] = y_q + bus_word;
            op_sub: result[word_width-1:0] = y_q - bus_word;
            op_and: result[word_width-1:0] = y_q & bus_word;
            op_or:  result[word_width-1:0] = y_q | bus_word;
            op_shr: result[word_width-1:0] = y_q >> bus_word[4:0];
            op_shl: result[word_width-1:0] = y_q << bus_word[4:0];
            op_neg: result[word_width-1:0] = -bus_word;
            op_not: result[word_width-1:0] = ~bus_word;
            // Signed operands widen to 64 bits before the multiply
            op_mul: result = $signed(y_q) * $signed(bus_word);
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            z_q <= '0;
        end else if (z_in) begin
            z_q <= result;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (hi_in) begin
                hi <= bus_word;
            end
            if (lo_in) begin
                lo <= bus_word;
            end
        end
    end

    assign zhigh = z_q[dword_width-1:word_width];
    assign zlow  = z_q[word_width-1:0];

endmodule

`default_nettype wire

/* logic/bus_driver.sv */
`default_nettype none

module bus_driver
    import cpu_defs_pkg::*;
(
    bus_if.driver      regs,
    input  wire word_t hi,
    input  wire word_t lo,
    input  wire word_t zhigh,
    input  wire word_t zlow,
    input  wire word_t in_word,
    input  wire word_t imm,
    input  wire logic  hi_out,
    input  wire logic  lo_out,
    input  wire logic  zhigh_out,
    input  wire logic  zlow_out,
    input  wire logic  in_port_out,
    input  wire logic  c_out
);

    bus_src_t src;

    // Descending priority encoder over the drive strobes
    always_comb begin
        src = src_none;
        if (c_out) begin
            src = src_imm;
        end else if (in_port_out) begin
            src = src_in_port;
        end else if (zlow_out) begin
            src = src_zlow;
        end else if (zhigh_out) begin
            src = src_zhigh;
        end else if (lo_out) begin
            src = src_lo;
        end else if (hi_out) begin
            src = src_hi;
        end else if (regs.gpr_drive) begin
            src = bus_src_t'({1'b0, regs.gpr_index});
        end
    end

    // Bus mux
    always_comb begin
        if (src <= src_r15) begin
            // Register file already presents the indexed word
            regs.bus = regs.gpr_data;
        end else begin
            case (src)
                src_hi:      regs.bus = hi;
                src_lo:      regs.bus = lo;
                src_zhigh:   regs.bus = zhigh;
                src_zlow:    regs.bus = zlow;
                src_in_port: regs.bus = in_word;
                src_imm:     regs.bus = imm;
                default:     regs.bus = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/bus_if.sv */
`default_nettype none

interface bus_if
    import cpu_defs_pkg::*;
();

    word_t                      bus;
    word_t                      gpr_data;
    logic [gpr_index_width-1:0] gpr_index;
    logic                       gpr_load;
    logic                       gpr_drive;

    modport driver (
        output bus,
        input  gpr_data,
        input  gpr_index,
        input  gpr_drive
    );

    modport file (
        input  bus,
        input  gpr_index,
        input  gpr_load,
        output gpr_data
    );

    modport decode (
        output gpr_index,
        output gpr_load,
        output gpr_drive
    );

endinterface

`default_nettype wire

/* logic/cpu_defs_pkg.sv */
`default_nettype none

package cpu_defs_pkg;

    localparam int word_width      = 32;
    localparam int gpr_count       = 16;
    localparam int gpr_index_width = 4;

    // Instruction register field positions
    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 27;
    localparam int ra_msb     = 26;
    localparam int ra_lsb     = 23;
    localparam int rb_msb     = 22;
    localparam int rb_lsb     = 19;
    localparam int rc_msb     = 18;
    localparam int rc_lsb     = 15;
    localparam int imm_msb    = 18;
    localparam int imm_width  = 19;

    typedef logic [word_width-1:0] word_t;

    // Bus source codes, higher code wins when several drive
    typedef enum logic [4:0] {
        src_r0 = 5'd0, src_r1, src_r2, src_r3,
        src_r4, src_r5, src_r6, src_r7,
        src_r8, src_r9, src_r10, src_r11,
        src_r12, src_r13, src_r14, src_r15,
        src_hi      = 5'd16,
        src_lo      = 5'd17,
        src_zhigh   = 5'd18,
        src_zlow    = 5'd19,
        src_in_port = 5'd20,
        src_imm     = 5'd21,
        src_none    = 5'd31
    } bus_src_t;

endpackage

`default_nettype wire

/* logic/datapath_top.sv */
`default_nettype none

module datapath_top
    import cpu_defs_pkg::*;
    import alu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    ir_in,
    input  wire logic    y_in,
    input  wire logic    z_in,
    input  wire logic    hi_in,
    input  wire logic    lo_in,
    input  wire logic    out_port_in,
    input  wire logic    gra,
    input  wire logic    grb,
    input  wire logic    grc,
    input  wire logic    r_in,
    input  wire logic    r_out,
    input  wire logic    ba_out,
    input  wire logic    hi_out,
    input  wire logic    lo_out,
    input  wire logic    zhigh_out,
    input  wire logic    zlow_out,
    input  wire logic    in_port_out,
    input  wire logic    c_out,
    input  wire alu_op_t opcode,
    input  wire word_t   in_data,
    output word_t        bus_value,
    output word_t        out_port
);

    word_t hi;
    word_t lo;
    word_t zhigh;
    word_t zlow;
    word_t imm;
    word_t in_port_q;

    bus_if bus_inst ();

    ir_decode ir_decode_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .ir_in    (ir_in),
        .gra      (gra),
        .grb      (grb),
        .grc      (grc),
        .r_in     (r_in),
        .r_out    (r_out),
        .bus_word (bus_inst.bus),
        .regs     (bus_inst.decode),
        .imm      (imm)
    );

    bus_driver bus_driver_inst (
        .regs        (bus_inst.driver),
        .hi          (hi),
        .lo          (lo),
        .zhigh       (zhigh),
        .zlow        (zlow),
        .in_word     (in_port_q),
        .imm         (imm),
        .hi_out      (hi_out),
        .lo_out      (lo_out),
        .zhigh_out   (zhigh_out),
        .zlow_out    (zlow_out),
        .in_port_out (in_port_out),
        .c_out       (c_out)
    );

    gpr_file gpr_file_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .ba_out (ba_out),
        .regs   (bus_inst.file)
    );

    alu_stage alu_stage_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .y_in     (y_in),
        .z_in     (z_in),
        .hi_in    (hi_in),
        .lo_in    (lo_in),
        .opcode   (opcode),
        .bus_word (bus_inst.bus),
        .hi       (hi),
        .lo       (lo),
        .zhigh    (zhigh),
        .zlow     (zlow)
    );

    // Input port has no enable, samples every edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_port_q <= '0;
        end else begin
            in_port_q <= in_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_port <= '0;
        end else if (out_port_in) begin
            out_port <= bus_inst.bus;
        end
    end

    assign bus_value = bus_inst.bus;

endmodule

`default_nettype wire

/* logic/gpr_file.sv */
`default_nettype none

module gpr_file
    import cpu_defs_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic ba_out,
    bus_if.file       regs
);

    word_t gpr [gpr_count];
    logic  r0_masked;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < gpr_count; i++) begin
                gpr[i] <= '0;
            end
        end else if (regs.gpr_load) begin
            gpr[regs.gpr_index] <= regs.bus;
        end
    end

    // R0 reads as zero for base-address use
    assign r0_masked = ba_out && (regs.gpr_index == '0);

    assign regs.gpr_data = r0_masked ? '0 : gpr[regs.gpr_index];

endmodule

`default_nettype wire

/* logic/ir_decode.sv */
`default_nettype none

module ir_decode
    import cpu_defs_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   ir_in,
    input  wire logic   gra,
    input  wire logic   grb,
    input  wire logic   grc,
    input  wire logic   r_in,
    input  wire logic   r_out,
    input  wire word_t  bus_word,
    bus_if.decode       regs,
    output word_t       imm
);

    word_t ir;
    logic  sel_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (ir_in) begin
            ir <= bus_word;
        end
    end

    // Field select, gra over grb over grc
    always_comb begin
        regs.gpr_index = '0;
        if (gra) begin
            regs.gpr_index = ir[ra_msb:ra_lsb];
        end else if (grb) begin
            regs.gpr_index = ir[rb_msb:rb_lsb];
        end else if (grc) begin
            regs.gpr_index = ir[rc_msb:rc_lsb];
        end
    end

    assign sel_valid = gra | grb | grc;

    assign regs.gpr_load  = r_in & sel_valid;
    assign regs.gpr_drive = r_out & sel_valid;

    // C constant, sign extended to a full word
    assign imm = {{(word_width - imm_width){ir[imm_msb]}}, ir[imm_msb -: imm_width]};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module datapath_tb -f src.f

./obj_dir/Vdatapath_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* src.f */
logic/cpu_defs_pkg.sv
logic/alu_pkg.sv
logic/bus_if.sv
logic/ir_decode.sv
logic/bus_driver.sv
logic/gpr_file.sv
logic/alu_stage.sv
logic/datapath_top.sv
testbench/datapath_sva.sv
testbench/datapath_tb.sv

/* testbench/datapath_sva.sv */
`default_nettype none

module datapath_sva
    import cpu_defs_pkg::*;
(
    input wire logic  clk,
    input wire logic  arst_n,
    input wire logic  out_port_in,
    input wire logic  r_out,
    input wire logic  hi_out,
    input wire logic  lo_out,
    input wire logic  zhigh_out,
    input wire logic  zlow_out,
    input wire logic  in_port_out,
    input wire logic  c_out,
    input wire word_t bus_value,
    input wire word_t out_port
);

    timeunit 1ns;
    timeprecision 1ps;

    logic any_drive;
    int   fail_count = 0;

    assign any_drive = r_out | hi_out | lo_out | zhigh_out | zlow_out | in_port_out | c_out;

    // Output port only moves after a load strobe
    out_port_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !out_port_in |=> $stable(out_port))
        else begin
            fail_count++;
            $error("out_port changed without out_port_in on the previous edge");
        end

    bus_idle_zero: assert property (@(posedge clk) disable iff (!arst_n)
        !any_drive |-> bus_value == '0)
        else begin
            fail_count++;
            $error("bus_value is not zero with no drive strobe high");
        end

    out_port_reset: assert property (@(posedge clk) !arst_n |-> out_port == '0)
        else begin
            fail_count++;
            $error("out_port is not zero during reset");
        end

endmodule

`default_nettype wire

/* testbench/datapath_tb.sv */
`default_nettype none

module datapath_tb
    import cpu_defs_pkg::*;
    import alu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Strobe masks, bit order matches the DUT hookup below
    localparam logic [17:0] s_ir_in       = 18'h00001;
    localparam logic [17:0] s_y_in        = 18'h00002;
    localparam logic [17:0] s_z_in        = 18'h00004;
    localparam logic [17:0] s_hi_in       = 18'h00008;
    localparam logic [17:0] s_lo_in       = 18'h00010;
    localparam logic [17:0] s_out_port_in = 18'h00020;
    localparam logic [17:0] s_gra         = 18'h00040;
    localparam logic [17:0] s_grb         = 18'h00080;
    localparam logic [17:0] s_grc         = 18'h00100;
    localparam logic [17:0] s_r_in        = 18'h00200;
    localparam logic [17:0] s_r_out       = 18'h00400;
    localparam logic [17:0] s_ba_out      = 18'h00800;
    localparam logic [17:0] s_hi_out      = 18'h01000;
    localparam logic [17:0] s_lo_out      = 18'h02000;
    localparam logic [17:0] s_zhigh_out   = 18'h04000;
    localparam logic [17:0] s_zlow_out    = 18'h08000;
    localparam logic [17:0] s_in_port_out = 18'h10000;
    localparam logic [17:0] s_c_out       = 18'h20000;

    logic         clk;
    logic         arst_n;
    logic [17:0]  ctrl;
    alu_op_t      opcode;
    word_t        in_data;
    word_t        bus_value;
    word_t        out_port;
    integer       seed = 32'h58c178e1;
    int           errors = 0;
    int           checks = 0;
    logic         table_ready = 1'b0;

    // Stimulus table with expected values
    logic [17:0]  row_ctrl[$];
    alu_op_t      row_op[$];
    word_t        row_in[$];
    word_t        row_exp_bus[$];
    word_t        row_exp_out[$];

    // Reference model state
    word_t        ref_gpr [gpr_count];
    word_t        ref_ir;
    word_t        ref_y;
    word_t        ref_hi;
    word_t        ref_lo;
    word_t        ref_in;
    word_t        ref_out;
    logic [63:0]  ref_z;

    datapath_top datapath_top_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .ir_in       (ctrl[0]),
        .y_in        (ctrl[1]),
        .z_in        (ctrl[2]),
        .hi_in       (ctrl[3]),
        .lo_in       (ctrl[4]),
        .out_port_in (ctrl[5]),
        .gra         (ctrl[6]),
        .grb         (ctrl[7]),
        .grc         (ctrl[8]),
        .r_in        (ctrl[9]),
        .r_out       (ctrl[10]),
        .ba_out      (ctrl[11]),
        .hi_out      (ctrl[12]),
        .lo_out      (ctrl[13]),
        .zhigh_out   (ctrl[14]),
        .zlow_out    (ctrl[15]),
        .in_port_out (ctrl[16]),
        .c_out       (ctrl[17]),
        .opcode      (opcode),
        .in_data     (in_data),
        .bus_value   (bus_value),
        .out_port    (out_port)
    );

    bind datapath_top datapath_sva datapath_sva_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .out_port_in (out_port_in),
        .r_out       (r_out),
        .hi_out      (hi_out),
        .lo_out      (lo_out),
        .zhigh_out   (zhigh_out),
        .zlow_out    (zlow_out),
        .in_port_out (in_port_out),
        .c_out       (c_out),
        .bus_value   (bus_value),
        .out_port    (out_port)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic has_strobe(input logic [17:0] c, input logic [17:0] m);
        return |(c & m);
    endfunction

    // Y is operand A, the bus is operand B
    function automatic logic [63:0] alu_expected(input alu_op_t op, input word_t a,
                                                 input word_t b);
        logic [63:0] wide_a;
        logic [63:0] wide_b;
        wide_a = {{32{a[31]}}, a};
        wide_b = {{32{b[31]}}, b};
        case (op)
            op_add:  return {32'd0, a + b};
            op_sub:  return {32'd0, a - b};
            op_and:  return {32'd0, a & b};
            op_or:   return {32'd0, a | b};
            op_shr:  return {32'd0, a >> b[4:0]};
            op_shl:  return {32'd0, a << b[4:0]};
            op_neg:  return {32'd0, 32'd0 - b};
            op_not:  return {32'd0, ~b};
            op_mul:  return wide_a * wide_b;
            default: return 64'd0;
        endcase
    endfunction

    // Model one cycle, record expectations, then apply the edge
    task automatic add_row(input logic [17:0] c, input alu_op_t op, input word_t din);
        word_t      bus;
        logic [3:0] idx;
        logic       sel;
        idx = has_strobe(c, s_gra) ? ref_ir[26:23] :
              has_strobe(c, s_grb) ? ref_ir[22:19] :
              has_strobe(c, s_grc) ? ref_ir[18:15] : 4'd0;
        sel = has_strobe(c, s_gra | s_grb | s_grc);
        if (has_strobe(c, s_c_out)) bus = {{13{ref_ir[18]}}, ref_ir[18:0]};
        else if (has_strobe(c, s_in_port_out)) bus = ref_in;
        else if (has_strobe(c, s_zlow_out)) bus = ref_z[31:0];
        else if (has_strobe(c, s_zhigh_out)) bus = ref_z[63:32];
        else if (has_strobe(c, s_lo_out)) bus = ref_lo;
        else if (has_strobe(c, s_hi_out)) bus = ref_hi;
        else if (has_strobe(c, s_r_out) && sel) begin
            bus = (has_strobe(c, s_ba_out) && idx == 4'd0) ? '0 : ref_gpr[idx];
        end else bus = '0;
        row_ctrl.push_back(c);
        row_op.push_back(op);
        row_in.push_back(din);
        row_exp_bus.push_back(bus);
        row_exp_out.push_back(ref_out);
        if (has_strobe(c, s_ir_in)) ref_ir = bus;
        if (has_strobe(c, s_y_in)) ref_y = bus;
        if (has_strobe(c, s_z_in)) ref_z = alu_expected(op, ref_y, bus);
        if (has_strobe(c, s_hi_in)) ref_hi = bus;
        if (has_strobe(c, s_lo_in)) ref_lo = bus;
        if (has_strobe(c, s_out_port_in)) ref_out = bus;
        if (has_strobe(c, s_r_in) && sel) ref_gpr[idx] = bus;
        ref_in = din;
    endtask

    task automatic load_ir(input word_t instr);
        add_row('0, op_add, instr);
        add_row(s_in_port_out | s_ir_in, op_add, '0);
    endtask

    task automatic load_reg(input logic [17:0] sel, input word_t data);
        add_row('0, op_add, data);
        add_row(s_in_port_out | sel | s_r_in, op_add, '0);
    endtask

    task automatic alu_sequence(input alu_op_t op, input word_t a, input word_t b);
        add_row('0, op, a);
        add_row(s_in_port_out | s_y_in, op, b);
        add_row(s_in_port_out | s_z_in, op, '0);
        add_row(s_zlow_out | s_out_port_in, op, '0);
        add_row(s_zhigh_out, op, '0);
    endtask

    task automatic build_table();
        word_t   instr;
        alu_op_t op_list[9];
        op_list = '{op_add, op_sub, op_and, op_or, op_shr, op_shl, op_neg, op_not, op_mul};
        for (int i = 0; i < gpr_count; i++) begin
            ref_gpr[i] = '0;
        end
        {ref_ir, ref_y, ref_hi, ref_lo, ref_in, ref_out} = '0;
        ref_z = '0;
        // Reset state
        add_row('0, op_add, '0);
        add_row(s_out_port_in, op_add, '0);
        // Register access through each IR field
        instr = $random(seed);
        instr[ra_msb:ra_lsb] = 4'd5;
        instr[rb_msb:rb_lsb] = 4'd9;
        instr[rc_msb:rc_lsb] = 4'd14;
        load_ir(instr);
        load_reg(s_gra, $random(seed));
        load_reg(s_grb, $random(seed));
        load_reg(s_grc, $random(seed));
        add_row(s_gra | s_r_out, op_add, '0);
        add_row(s_grb | s_r_out | s_out_port_in, op_add, '0);
        add_row(s_grc | s_r_out, op_add, '0);
        // R0 masking under ba_out
        instr[ra_msb:ra_lsb] = 4'd0;
        instr[rb_msb:rb_lsb] = 4'd5;
        load_ir(instr);
        load_reg(s_gra, $random(seed));
        add_row(s_gra | s_r_out | s_ba_out, op_add, '0);
        add_row(s_gra | s_r_out, op_add, '0);
        add_row(s_grb | s_r_out | s_ba_out, op_add, '0);
        foreach (op_list[i]) begin
            alu_sequence(op_list[i], $random(seed), $random(seed));
        end
        // HI and LO round trip
        add_row('0, op_add, $random(seed));
        add_row(s_in_port_out | s_hi_in, op_add, $random(seed));
        add_row(s_in_port_out | s_lo_in, op_add, '0);
        add_row(s_hi_out, op_add, '0);
        add_row(s_lo_out | s_out_port_in, op_add, '0);
        add_row('0, op_add, '0);
        // Sign-extended constant, positive then negative
        instr = $random(seed);
        instr[imm_msb] = 1'b0;
        load_ir(instr);
        add_row(s_c_out, op_add, '0);
        instr[imm_msb] = 1'b1;
        load_ir(instr);
        add_row(s_c_out | s_out_port_in, op_add, '0);
        add_row('0, op_add, $random(seed));
        // Competing drivers
        add_row(s_c_out | s_in_port_out, op_add, $random(seed));
        add_row(s_in_port_out | s_zlow_out, op_add, '0);
        add_row(s_zlow_out | s_zhigh_out | s_hi_out, op_add, '0);
        add_row(s_lo_out | s_hi_out, op_add, '0);
        add_row(s_hi_out | s_gra | s_r_out, op_add, '0);
        add_row(s_lo_out | s_grc | s_r_out, op_add, '0);
    endtask

    initial begin
        ctrl = '0;
        opcode = op_add;
        in_data = '0;
        arst_n = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < row_ctrl.size(); i++) begin
            @(posedge clk);
            ctrl <= row_ctrl[i];
            opcode <= row_op[i];
            in_data <= row_in[i];
            @(negedge clk);
            checks += 2;
            assert (bus_value === row_exp_bus[i]) else begin
                errors++;
                $display("[ERROR] row %0d bus_value: got %h, expected %h",
                         i, bus_value, row_exp_bus[i]);
            end
            assert (out_port === row_exp_out[i]) else begin
                errors++;
                $display("[ERROR] row %0d out_port: got %h, expected %h",
                         i, out_port, row_exp_out[i]);
            end
        end
        $display("Rows: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 row_ctrl.size(), checks, errors,
                 datapath_top_inst.datapath_sva_inst.fail_count);
        if (errors == 0 && datapath_top_inst.datapath_sva_inst.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, sized from the table length
    initial begin
        wait (table_ready);
        #((row_ctrl.size() + 10 + 50) * 20);
        $display("Timeout: the stimulus table did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
